// File: tb.f
common/soc_pkg.sv
common/wb_if.sv
intc/simple_pic.sv
intc/tick_timer.sv
src/ram_slave.sv
src/gpio_port.sv
src/wb_switch.sv
src/soc_top.sv
verif/soc_properties.sv
verif/soc_checker.sv
verif/tb_top.sv

// File: verif/tb_top.sv
////////////////////////////////////////////////////////////
// testbench top: clock, reset, DUT, checker, bus and
// interrupt stimulus tasks, run timeout
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_top;

  localparam int RAM_AW      = 8;
  localparam int TICK_PERIOD = 200;
  localparam int MAX_CYCLES  = 60 * 4 + 3 * TICK_PERIOD + 160; // about 1000 cycles
  localparam logic [18:0] GPIO_W0 = 19'h7880;                  // io byte 0xf100

  logic        clk;
  logic        rst_lck;
  logic [18:0] wb_adr_i;
  logic        wb_tga_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [1:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic        inta_i;
  logic        intr_o;
  logic [7:1]  irq_i;
  logic [15:0] sw_i;
  logic [15:0] leds_o;
  logic [2:0]  vec_line;  // line the next acknowledge should report
  logic        intr_chk;
  int          data_errors;
  int          cycle_cnt = 0;
  integer      seed;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  soc_top #(
    .RAM_AW      (RAM_AW),
    .TICK_PERIOD (TICK_PERIOD)
  ) soc_top_inst (.*);

  soc_checker #(
    .RAM_AW      (RAM_AW),
    .TICK_PERIOD (TICK_PERIOD)
  ) soc_checker_inst (
    .clk           (clk),
    .rst_lck       (rst_lck),
    .wb_adr_i      (wb_adr_i),
    .wb_tga_i      (wb_tga_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_r_i    (wb_dat_o),
    .wb_sel_i      (wb_sel_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_i      (wb_ack_o),
    .inta_i        (inta_i),
    .intr_i        (intr_o),
    .irq_i         (irq_i),
    .sw_i          (sw_i),
    .leds_i        (leds_o),
    .vec_line_i    (vec_line),
    .intr_chk_i    (intr_chk),
    .error_count_o (data_errors)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // one classic cycle, held until the ack edge
  task automatic run_transfer(input logic we, input logic tga, input logic [18:0] adr,
                              input logic [15:0] dat, input logic [1:0] sel);
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_tga_i <= tga;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    @(posedge clk);
    while (!wb_ack_o) @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_word(input logic tga, input logic [18:0] adr,
                            input logic [15:0] dat, input logic [1:0] sel);
    run_transfer(1'b1, tga, adr, dat, sel);
  endtask

  task automatic read_word(input logic tga, input logic [18:0] adr);
    run_transfer(1'b0, tga, adr, 16'h0000, 2'b11);
  endtask

  task automatic pulse_irq(input int line);
    @(posedge clk);
    irq_i[line] <= 1'b1;
    @(posedge clk);
    irq_i[line] <= 1'b0;
  endtask

  // CPU side acknowledge, vector compared by the checker
  task automatic acknowledge_irq(input logic [2:0] line);
    @(posedge clk);
    while (!intr_o) @(posedge clk);
    vec_line <= line;
    inta_i   <= 1'b1;
    @(posedge clk);
    inta_i   <= 1'b0;
    repeat (3) @(posedge clk); // pending clear, then next id
  endtask

  task automatic expect_intr_low();
    @(posedge clk);
    intr_chk <= 1'b1;
    @(posedge clk);
    intr_chk <= 1'b0;
  endtask

  initial begin : stimulus
    logic [18:0] ram_adr [8];
    logic [18:0] a;
    seed     = 82;
    rst_lck  = 1'b0;
    wb_adr_i = '0;
    wb_tga_i = 1'b0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    inta_i   = 1'b0;
    irq_i    = '0;
    sw_i     = '0;
    vec_line = '0;
    intr_chk = 1'b0;
    repeat (3) @(posedge clk);
    rst_lck <= 1'b1;
    // full words first so every later read is defined
    for (int i = 0; i < 8; i++) begin
      ram_adr[i] = 19'($random(seed));
      write_word(1'b0, ram_adr[i], 16'($random(seed)), 2'b11);
    end
    for (int i = 0; i < 8; i++) begin
      write_word(1'b0, ram_adr[i], 16'($random(seed)), 2'($random(seed)));
    end
    for (int i = 0; i < 8; i++) begin
      a = ram_adr[i] ^ (19'($random(seed)) << RAM_AW); // same word, other alias
      read_word(1'b0, a);
    end
    for (int i = 0; i < 8; i++) read_word(1'b0, ram_adr[i]);
    // switch / LED port
    sw_i <= 16'($random(seed));
    write_word(1'b1, GPIO_W0, 16'($random(seed)), 2'b11);
    write_word(1'b1, GPIO_W0, 16'($random(seed)), 2'b01);
    write_word(1'b1, GPIO_W0, 16'($random(seed)), 2'b10);
    read_word(1'b1, GPIO_W0);
    read_word(1'b1, GPIO_W0 | 19'd1);
    sw_i <= 16'($random(seed));
    read_word(1'b1, GPIO_W0);
    // unmapped io
    read_word(1'b1, GPIO_W0 + 19'd2);
    read_word(1'b1, 19'd0);
    a = 19'($random(seed));
    if (a[14:1] == GPIO_W0[14:1]) a[1] = ~a[1];
    read_word(1'b1, a);
    a = ram_adr[0];
    if (a[14:1] == GPIO_W0[14:1]) a[1] = ~a[1];
    write_word(1'b1, a, 16'($random(seed)), 2'b11); // io twin of a RAM word
    read_word(1'b0, ram_adr[0]);
    read_word(1'b1, GPIO_W0 | 19'd1);
    // timer first, then two external lines
    acknowledge_irq(3'd0);
    expect_intr_low();
    pulse_irq(5);
    pulse_irq(3);
    acknowledge_irq(3'd3);
    acknowledge_irq(3'd5);
    expect_intr_low();
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("summary: %0d data errors, %0d assertion errors", data_errors,
             soc_top_inst.soc_properties_inst.assert_errors);
    if (data_errors == 0 && soc_top_inst.soc_properties_inst.assert_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verif/soc_checker.sv
////////////////////////////////////////////////////////////
// checker: RAM and LED shadow, reference read function,
// comparing process and error count
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module soc_checker #(
  parameter int RAM_AW      = 8,
  parameter int TICK_PERIOD = 200
) (
  input  logic        clk,
  input  logic        rst_lck,
  input  logic [18:0] wb_adr_i,
  input  logic        wb_tga_i,
  input  logic [15:0] wb_dat_i,
  input  logic [15:0] wb_dat_r_i,  // DUT read data
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_ack_i,
  input  logic        inta_i,
  input  logic        intr_i,
  input  logic [7:1]  irq_i,
  input  logic [15:0] sw_i,
  input  logic [15:0] leds_i,
  input  logic [2:0]  vec_line_i,
  input  logic        intr_chk_i,  // intr_o must be low on this edge
  output int          error_count_o
);

  localparam logic [18:0] GPIO_W0  = 19'h7880; // io bytes 0xf100..0xf103
  localparam logic [15:0] VEC_BASE = 16'd8;
  localparam logic [15:0] UNMAPPED = 16'hffff;

  logic [15:0] ram_shadow [2**RAM_AW];
  logic [15:0] led_shadow;
  logic        waiting;   // request sampled, no ack yet
  logic        tick_seen;
  logic        ext_seen;
  int          since_rst;

  function automatic logic [15:0] merge_lanes(input logic [15:0] old,
                                              input logic [15:0] dat, input logic [1:0] sel);
    return {sel[1] ? dat[15:8] : old[15:8], sel[0] ? dat[7:0] : old[7:0]};
  endfunction

  function automatic logic [15:0] expected_read(input logic tga, input logic [18:0] adr,
                                                input logic [15:0] sw);
    if (!tga) return ram_shadow[adr[RAM_AW-1:0]]; // aliases every 2**RAM_AW words
    if (adr[18:1] == GPIO_W0[18:1]) return adr[0] ? led_shadow : sw;
    return UNMAPPED;
  endfunction

  task automatic fail_line(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    error_count_o++;
  endtask

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) fail_line($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  always @(posedge clk) begin
    if (!rst_lck) begin
      led_shadow = '0;
      waiting    = 1'b0;
      tick_seen  = 1'b0;
      ext_seen   = 1'b0;
      since_rst  = 0;
    end else begin
      since_rst++;
      if (since_rst == 1 && (wb_ack_i || intr_i || leds_i != '0))
        fail_line("ack, intr_o or leds_o not low after reset");
      // ack exactly one edge after the request is first seen
      if (wb_ack_i && !waiting) fail_line("ack without a request on the previous edge");
      if (wb_cyc_i && wb_stb_i && !wb_ack_i && waiting) fail_line("no ack one edge after stb");
      waiting = wb_cyc_i && wb_stb_i && !wb_ack_i;
      if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
        if (!wb_we_i) begin
          check_word(wb_dat_r_i, expected_read(wb_tga_i, wb_adr_i, sw_i), "read data");
        end else if (!wb_tga_i) begin
          ram_shadow[wb_adr_i[RAM_AW-1:0]] =
            merge_lanes(ram_shadow[wb_adr_i[RAM_AW-1:0]], wb_dat_i, wb_sel_i);
        end else if (wb_adr_i[18:1] == GPIO_W0[18:1]) begin
          led_shadow = merge_lanes(led_shadow, wb_dat_i, wb_sel_i);
        end // other io writes land nowhere
      end
      check_word(leds_i, led_shadow, "leds_o");
      if (inta_i) check_word(wb_dat_r_i, VEC_BASE + 16'(vec_line_i), "interrupt vector");
      if (intr_chk_i && intr_i) fail_line("intr_o still high after the last acknowledge");
      // first interrupt comes from the timer alone
      if (irq_i != '0) ext_seen = 1'b1;
      if (!tick_seen && !ext_seen && intr_i) begin
        tick_seen = 1'b1;
        if (since_rst - 1 > TICK_PERIOD + 2) fail_line("timer interrupt came too late");
      end else if (!tick_seen && !ext_seen && since_rst > TICK_PERIOD + 3) begin
        tick_seen = 1'b1;
        fail_line("intr_o never rose from the timer");
      end
    end
  end

endmodule

// File: verif/soc_properties.sv
////////////////////////////////////////////////////////////
// handshake and interrupt assertions, bound into soc_top
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module soc_properties (
  input logic clk,
  input logic rst_lck,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic intr_i
);

  int assert_errors = 0;

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_lck)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
      $error("ack seen without cyc and stb");
      assert_errors++;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("ack held longer than one cycle");
      assert_errors++;
    end

  // first cycle out of reset
  intr_low_after_rst: assert property (@(posedge clk) $rose(rst_lck) |-> !intr_i)
    else begin
      $error("intr_o high right after reset");
      assert_errors++;
    end

endmodule

bind soc_top soc_properties soc_properties_inst (
  .clk      (clk),
  .rst_lck  (rst_lck),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .intr_i   (intr_o)
);

// File: src/soc_top.sv
////////////////////////////////////////////////////////////
// system bus core top level: Wishbone switch, word RAM,
// switch/LED port, interrupt controller and tick timer
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module soc_top #(
  parameter int RAM_AW      = 8,   // RAM depth is 2**RAM_AW words
  parameter int TICK_PERIOD = 200  // timer interrupt period in clocks
) (
  input  logic                        clk,
  input  logic                        rst_lck,
  // Wishbone master side, driven by the CPU
  input  logic [soc_pkg::ADR_W-1:0]   wb_adr_i,
  input  logic                        wb_tga_i,
  input  logic [soc_pkg::DAT_W-1:0]   wb_dat_i,
  output logic [soc_pkg::DAT_W-1:0]   wb_dat_o,
  input  logic [soc_pkg::SEL_W-1:0]   wb_sel_i,
  input  logic                        wb_we_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  output logic                        wb_ack_o,
  // interrupt handshake with the CPU
  input  logic                        inta_i,
  output logic                        intr_o,
  input  logic [soc_pkg::NUM_IRQ-1:1] irq_i,
  // board io
  input  logic [soc_pkg::DAT_W-1:0]   sw_i,
  output logic [soc_pkg::DAT_W-1:0]   leds_o
);

  wb_if m_bus ();
  wb_if ram_bus ();
  wb_if gpio_bus ();

  logic                          tick;
  logic [soc_pkg::NUM_IRQ-1:0]   irq_all;
  logic [soc_pkg::IRQ_ID_W-1:0]  irq_id;

  // plain ports onto the master side of the switch
  assign m_bus.adr   = wb_adr_i;
  assign m_bus.tga   = wb_tga_i;
  assign m_bus.dat_w = wb_dat_i;
  assign m_bus.sel   = wb_sel_i;
  assign m_bus.we    = wb_we_i;
  assign m_bus.cyc   = wb_cyc_i;
  assign m_bus.stb   = wb_stb_i;
  assign wb_dat_o    = m_bus.dat_r;
  assign wb_ack_o    = m_bus.ack;

  assign irq_all = {irq_i, tick}; // system timer on line 0

  wb_switch wb_switch_inst (
    .clk      (clk),
    .rst_lck  (rst_lck),
    .m        (m_bus.slave),
    .ram      (ram_bus.master),
    .gpio     (gpio_bus.master),
    .inta_i   (inta_i),
    .irq_id_i (irq_id)
  );

  ram_slave #(
    .RAM_AW (RAM_AW)
  ) ram_slave_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (ram_bus.slave)
  );

  gpio_port gpio_port_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (gpio_bus.slave),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  simple_pic simple_pic_inst (
    .clk      (clk),
    .rst_lck  (rst_lck),
    .irq_i    (irq_all),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .irq_id_o (irq_id)
  );

  tick_timer #(
    .TICK_PERIOD (TICK_PERIOD)
  ) tick_timer_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tick_o  (tick)
  );

endmodule

// File: src/wb_switch.sv
////////////////////////////////////////////////////////////
// Wishbone classic switch: address decode, stb routing,
// default slave and interrupt vector read path
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module wb_switch (
  input  logic                          clk,
  input  logic                          rst_lck,
  wb_if.slave                           m,
  wb_if.master                          ram,
  wb_if.master                          gpio,
  input  logic                          inta_i,
  input  logic [soc_pkg::IRQ_ID_W-1:0]  irq_id_i
);

  soc_pkg::bus_state_e        state_q;
  soc_pkg::slave_e            slv;
  logic [soc_pkg::ADR_W:0]    tadr;
  logic                       req;
  logic                       def_ack_q;
  logic [soc_pkg::DAT_W-1:0]  slv_dat;
  logic [soc_pkg::DAT_W-1:0]  vector;

  assign tadr = {m.tga, m.adr};

  // memory space always hits RAM, io splits into gpio / default
  always_comb begin
    if (!m.tga) begin
      slv = soc_pkg::SLV_RAM;
    end else if ((tadr & soc_pkg::GPIO_IO_MASK) == soc_pkg::GPIO_IO_ADDR) begin
      slv = soc_pkg::SLV_GPIO;
    end else begin
      slv = soc_pkg::SLV_DEFAULT;
    end
  end

  // a new request is only taken in idle, so stb never hits twice
  assign req = m.cyc && m.stb && (state_q == soc_pkg::BUS_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      state_q   <= soc_pkg::BUS_IDLE;
      def_ack_q <= 1'b0;
    end else begin
      unique case (state_q)
        soc_pkg::BUS_IDLE: if (req) state_q <= soc_pkg::BUS_ACK;
        soc_pkg::BUS_ACK:  state_q <= soc_pkg::BUS_IDLE; // ack cycle done
        default:           state_q <= soc_pkg::BUS_IDLE;
      endcase
      def_ack_q <= req && (slv == soc_pkg::SLV_DEFAULT); // writes dropped
    end
  end

  // shared request lines, stb only to the selected slave
  assign ram.adr    = m.adr;
  assign ram.tga    = m.tga;
  assign ram.dat_w  = m.dat_w;
  assign ram.sel    = m.sel;
  assign ram.we     = m.we;
  assign ram.cyc    = m.cyc && (slv == soc_pkg::SLV_RAM);
  assign ram.stb    = req && (slv == soc_pkg::SLV_RAM);

  assign gpio.adr   = m.adr;
  assign gpio.tga   = m.tga;
  assign gpio.dat_w = m.dat_w;
  assign gpio.sel   = m.sel;
  assign gpio.we    = m.we;
  assign gpio.cyc   = m.cyc && (slv == soc_pkg::SLV_GPIO);
  assign gpio.stb   = req && (slv == soc_pkg::SLV_GPIO);

  // return path, address is held until ack so decode stays valid
  always_comb begin
    unique case (slv)
      soc_pkg::SLV_RAM: begin
        m.ack   = ram.ack;
        slv_dat = ram.dat_r;
      end
      soc_pkg::SLV_GPIO: begin
        m.ack   = gpio.ack;
        slv_dat = gpio.dat_r;
      end
      default: begin
        m.ack   = def_ack_q;
        slv_dat = soc_pkg::DEFAULT_DATA;
      end
    endcase
  end

  // interrupt acknowledge wins over any bus data
  assign vector  = soc_pkg::VEC_BASE + soc_pkg::DAT_W'(irq_id_i);
  assign m.dat_r = inta_i ? vector : slv_dat;

endmodule

// File: src/gpio_port.sv
////////////////////////////////////////////////////////////
// switch input and LED output port in the io window
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module gpio_port (
  input  logic                       clk,
  input  logic                       rst_lck,
  wb_if.slave                        bus,
  input  logic [soc_pkg::DAT_W-1:0]  sw_i,
  output logic [soc_pkg::DAT_W-1:0]  leds_o
);

  localparam int LANE_W = soc_pkg::DAT_W / soc_pkg::SEL_W;

  logic [soc_pkg::DAT_W-1:0] led_q;
  logic                      hit;
  logic                      ack_q;

  assign hit = bus.cyc && bus.stb && !ack_q;

  // LED register takes writes at either word of the window
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      led_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
      if (hit && bus.we) begin
        for (int i = 0; i < soc_pkg::SEL_W; i++) begin
          if (bus.sel[i]) led_q[i*LANE_W +: LANE_W] <= bus.dat_w[i*LANE_W +: LANE_W];
        end
      end
    end
  end

  // word 0 switches, word 1 LED readback
  always_ff @(posedge clk) begin
    if (hit) bus.dat_r <= bus.adr[0] ? led_q : sw_i;
  end

  assign bus.ack = ack_q;
  assign leds_o  = led_q;

endmodule

// File: src/ram_slave.sv
////////////////////////////////////////////////////////////
// on-chip word RAM with byte lanes, Wishbone slave
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ram_slave #(
  parameter int RAM_AW = 8
) (
  input  logic clk,
  input  logic rst_lck,
  wb_if.slave  bus
);

  localparam int LANE_W = soc_pkg::DAT_W / soc_pkg::SEL_W;

  logic [soc_pkg::DAT_W-1:0] mem [2**RAM_AW];
  logic [RAM_AW-1:0]         idx;
  logic                      hit;
  logic                      ack_q;

  assign idx = bus.adr[RAM_AW-1:0]; // upper word bits alias
  assign hit = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  // array and read register, no reset
  always_ff @(posedge clk) begin
    if (hit && bus.we) begin
      for (int i = 0; i < soc_pkg::SEL_W; i++) begin
        if (bus.sel[i]) mem[idx][i*LANE_W +: LANE_W] <= bus.dat_w[i*LANE_W +: LANE_W];
      end
    end
    if (hit) bus.dat_r <= mem[idx]; // old word on a write, unused
  end

  assign bus.ack = ack_q;

endmodule

// File: intc/tick_timer.sv
////////////////////////////////////////////////////////////
// periodic system tick for interrupt line 0
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tick_timer #(
  parameter int TICK_PERIOD = 200
) (
  input  logic clk,
  input  logic rst_lck,
  output logic tick_o
);

  localparam int              CNT_W = $clog2(TICK_PERIOD);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             tick_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      cnt_q  <= (cnt_q == LAST) ? '0 : cnt_q + 1'b1;
      tick_q <= (cnt_q == LAST); // one clock wide, on the wrap
    end
  end

  assign tick_o = tick_q;

endmodule

// File: intc/simple_pic.sv
////////////////////////////////////////////////////////////
// priority interrupt controller, eight edge requests,
// lowest line wins, pending bit cleared on acknowledge
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module simple_pic (
  input  logic                          clk,
  input  logic                          rst_lck,
  input  logic [soc_pkg::NUM_IRQ-1:0]   irq_i,
  input  logic                          inta_i,
  output logic                          intr_o,
  output logic [soc_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  logic [soc_pkg::NUM_IRQ-1:0]  irq_q;     // last sampled requests
  logic [soc_pkg::NUM_IRQ-1:0]  pending_q;
  logic [soc_pkg::NUM_IRQ-1:0]  rise;
  logic [soc_pkg::NUM_IRQ-1:0]  clr;
  logic [soc_pkg::IRQ_ID_W-1:0] lowest_id;
  logic [soc_pkg::IRQ_ID_W-1:0] id_q;
  logic                         inta_q;
  logic                         intr_q;

  assign rise = irq_i & ~irq_q;

  // end of acknowledge releases the line that was served
  always_comb begin
    clr = '0;
    if (inta_q && !inta_i) clr[id_q] = 1'b1;
  end

  // scan down so the lowest pending line is left
  always_comb begin
    lowest_id = '0;
    for (int i = soc_pkg::NUM_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i]) lowest_id = soc_pkg::IRQ_ID_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q     <= '0;
      pending_q <= '0;
      id_q      <= '0;
      inta_q    <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      irq_q     <= irq_i;
      pending_q <= (pending_q & ~clr) | rise; // new edge beats a clear
      inta_q    <= inta_i;
      intr_q    <= |pending_q;
      if (!inta_i) id_q <= lowest_id; // frozen during acknowledge
    end
  end

  assign intr_o   = intr_q;
  assign irq_id_o = id_q;

endmodule

// File: common/wb_if.sv
////////////////////////////////////////////////////////////
// Wishbone classic bus, 16 bit data, tagged address
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface wb_if;

  logic [soc_pkg::ADR_W-1:0] adr;   // word address, bits 19..1
  logic                      tga;   // 1 = io, 0 = memory
  logic [soc_pkg::DAT_W-1:0] dat_w; // master to slave
  logic [soc_pkg::DAT_W-1:0] dat_r; // slave to master
  logic [soc_pkg::SEL_W-1:0] sel;   // byte lanes
  logic                      we;
  logic                      cyc;
  logic                      stb;
  logic                      ack;

  modport master (
    output adr, tga, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, tga, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

// File: common/soc_pkg.sv
////////////////////////////////////////////////////////////
// system bus package: bus widths, io address map,
// slave and switch state enums, interrupt constants
////////////////////////////////////////////////////////////
package soc_pkg;

  // Wishbone bus geometry, word address covers bits 19..1
  localparam int ADR_W = 19;
  localparam int DAT_W = 16;
  localparam int SEL_W = 2;

  // interrupt controller
  localparam int NUM_IRQ  = 8;
  localparam int IRQ_ID_W = 3;

  // vector number of line 0, line k answers VEC_BASE + k
  localparam logic [DAT_W-1:0] VEC_BASE = 16'd8;

  // tagged address is {tga, adr}, tag 1 selects io space
  // io 0xf100 - 0xf103, two words
  localparam logic [ADR_W:0] GPIO_IO_ADDR = 20'b1_0000_1111_0001_0000_000;
  localparam logic [ADR_W:0] GPIO_IO_MASK = 20'b1_0000_1111_1111_1111_110;

  // unmapped io reads float high like an empty ISA slot
  localparam logic [DAT_W-1:0] DEFAULT_DATA = 16'hffff;

  // slave picked by the address decoder
  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_GPIO,
    SLV_DEFAULT
  } slave_e;

  // switch states, one ack cycle per transfer
  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } bus_state_e;

endpackage
